//--- hw/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

/////////////////////////////////////////
// Datapath widths
/////////////////////////////////////////

// Data and pc width
`define EXU_XLEN 64

// Word-aligned target, pc without its two low bits
`define EXU_TGTW 62

`define EXU_SHAMTW 7  // Shift amount bits taken from opb

`endif

//--- hw/alu_pkg.sv
package alu_pkg;

   // Operation encoding
   typedef enum logic [4:0] {
      ALU_LUI   = 5'd0,
      ALU_AUIPC = 5'd1,
      ALU_JAL   = 5'd2,
      ALU_JALR  = 5'd3,
      ALU_ADD   = 5'd4,
      ALU_SUB   = 5'd5,
      ALU_AND   = 5'd6,
      ALU_OR    = 5'd7,
      ALU_XOR   = 5'd8,
      ALU_SLL   = 5'd9,
      ALU_SRL   = 5'd10,
      ALU_SLT   = 5'd11,
      ALU_SLTU  = 5'd12,
      ALU_BEQ   = 5'd13,  // Conditional branches
      ALU_BNE   = 5'd14,
      ALU_BLT   = 5'd15,
      ALU_BGE   = 5'd16,
      ALU_BLTU  = 5'd17,
      ALU_BGEU  = 5'd18
   } alu_op_e;

   // Conditional branch, compared against rop2
   function automatic logic alu_is_branch(input alu_op_e op);
      case (op)
         ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // Unconditional, always flushes
   function automatic logic alu_is_jump(input alu_op_e op);
      return (op == ALU_JAL) || (op == ALU_JALR);
   endfunction

endpackage

//--- hw/exu_pkg.sv
`include "exu_settings.svh"

package exu_pkg;

   /////////////////////////////////////////
   // Stage payloads
   /////////////////////////////////////////

   typedef struct packed {
      alu_pkg::alu_op_e      op;
      logic [`EXU_XLEN-1:0]  pc;
      logic [`EXU_XLEN-1:0]  opa;
      logic [`EXU_XLEN-1:0]  opb;
      logic [`EXU_XLEN-1:0]  rop2;   // Second register, branch compare
      logic                  epoch;  // Front end epoch tag
   } exu_req_t;

   typedef struct packed {
      logic [`EXU_XLEN-1:0]  data;
      logic                  flush;   // Taken branch or jump
      logic [`EXU_TGTW-1:0]  pc_tgt;  // Word address
   } exu_res_t;

endpackage

//--- hw/exu_req_if.sv
`timescale 1ns/1ns
`include "exu_settings.svh"

interface exu_req_if;
   import alu_pkg::*;

   logic                  valid;
   logic                  ready;
   alu_op_e               op;
   logic [`EXU_XLEN-1:0]  pc;
   logic [`EXU_XLEN-1:0]  opa;
   logic [`EXU_XLEN-1:0]  opb;
   logic [`EXU_XLEN-1:0]  rop2;
   logic                  epoch;

   // Buffer side
   modport src (
      output valid, op, pc, opa, opb, rop2, epoch,
      input  ready
   );

   // Retire side
   modport dst (
      input  valid, op, pc, opa, opb, rop2, epoch,
      output ready
   );

endinterface

//--- hw/alu.sv
`timescale 1ns/1ns
`include "exu_settings.svh"

module alu (
   input  alu_pkg::alu_op_e      i_op,
   input  logic [`EXU_XLEN-1:0]  i_pc,
   input  logic [`EXU_XLEN-1:0]  i_opa,
   input  logic [`EXU_XLEN-1:0]  i_opb,
   input  logic [`EXU_XLEN-1:0]  i_rop2,
   output exu_pkg::exu_res_t     o_res
);
   import alu_pkg::*;

   logic [`EXU_XLEN-1:0] out_lui, out_auipc, out_jal;
   logic [`EXU_XLEN-1:0] out_add, out_sub, out_and, out_or, out_xor;
   logic [`EXU_XLEN-1:0] out_sll, out_srl;
   logic [`EXU_XLEN-1:0] out_slt, out_sltu;
   logic                 bcc;

   assign out_lui   = i_opb;
   assign out_auipc = i_pc + i_opb;

   // Arithmetic
   assign out_add = i_opa + i_opb;
   assign out_sub = i_opa - i_opb;

   // Logic
   assign out_and = i_opa & i_opb;
   assign out_or  = i_opa | i_opb;
   assign out_xor = i_opa ^ i_opb;

   // 7-bit amount, 64 and up shifts everything out
   assign out_sll = i_opa << i_opb[`EXU_SHAMTW-1:0];
   assign out_srl = i_opa >> i_opb[`EXU_SHAMTW-1:0];

   assign out_jal = {i_pc[`EXU_XLEN-1:2] + 1'b1, 2'b00};  // Link address

   // Compare
   assign out_slt  = ($signed(i_opa) < $signed(i_opb)) ? `EXU_XLEN'(1) : '0;
   assign out_sltu = (i_opa < i_opb) ? `EXU_XLEN'(1) : '0;

   /////////////////////////////////////////
   // Result select
   /////////////////////////////////////////

   always_comb begin
      case (i_op)
         ALU_LUI:            o_res.data = out_lui;
         ALU_AUIPC:          o_res.data = out_auipc;
         ALU_JAL, ALU_JALR:  o_res.data = out_jal;
         ALU_ADD:            o_res.data = out_add;
         ALU_SUB:            o_res.data = out_sub;
         ALU_AND:            o_res.data = out_and;
         ALU_OR:             o_res.data = out_or;
         ALU_XOR:            o_res.data = out_xor;
         ALU_SLL:            o_res.data = out_sll;
         ALU_SRL:            o_res.data = out_srl;
         ALU_SLT:            o_res.data = out_slt;
         ALU_SLTU:           o_res.data = out_sltu;
         default:            o_res.data = '0;  // Branches give zero
      endcase
   end

   /////////////////////////////////////////
   // Branch resolve
   /////////////////////////////////////////

   always_comb begin
      case (i_op)
         ALU_BEQ:  bcc = (i_opa == i_rop2);
         ALU_BNE:  bcc = (i_opa != i_rop2);
         ALU_BLT:  bcc = ($signed(i_opa) < $signed(i_rop2));
         ALU_BGE:  bcc = ($signed(i_opa) >= $signed(i_rop2));
         ALU_BLTU: bcc = (i_opa < i_rop2);
         ALU_BGEU: bcc = (i_opa >= i_rop2);
         default:  bcc = 1'b0;
      endcase
   end

   assign o_res.flush = alu_is_jump(i_op) | (alu_is_branch(i_op) & bcc);

   // Target in word units
   always_comb begin
      if ((i_op == ALU_JAL) || bcc) begin
         o_res.pc_tgt = i_pc[`EXU_XLEN-1:2] + i_opb[`EXU_XLEN-1:2];
      end else if (i_op == ALU_JALR) begin
         o_res.pc_tgt = i_opa[`EXU_XLEN-1:2] + i_opb[`EXU_XLEN-1:2];
      end else begin
         o_res.pc_tgt = '0;
      end
   end

endmodule

//--- hw/exu_issue_buf.sv
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_issue_buf (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic               i_req_valid,
   output logic               o_req_ready,
   input  exu_pkg::exu_req_t  i_req,
   exu_req_if.src             o_out
);
   import exu_pkg::*;

   typedef enum logic [1:0] {
      BUF_EMPTY = 2'd0,
      BUF_ONE   = 2'd1,
      BUF_TWO   = 2'd2
   } buf_state_e;

   buf_state_e state;
   exu_req_t   ent0;  // Oldest, shown downstream
   exu_req_t   ent1;
   logic       push;
   logic       pop;

   // Ready comes from state only
   assign o_req_ready = (state != BUF_TWO);
   assign push        = i_req_valid & o_req_ready;
   assign pop         = o_out.valid & o_out.ready;

   /////////////////////////////////////////
   // Occupancy
   /////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= BUF_EMPTY;
      end else begin
         case (state)
            BUF_EMPTY: if (push) state <= BUF_ONE;
            BUF_ONE:   if (push && !pop) state <= BUF_TWO;
                       else if (!push && pop) state <= BUF_EMPTY;
            BUF_TWO:   if (pop) state <= BUF_ONE;
            default:   state <= BUF_EMPTY;
         endcase
      end
   end

   // Entry payloads
   always_ff @(posedge i_clk) begin
      if ((state == BUF_EMPTY) || (state == BUF_ONE && pop)) begin
         if (push) ent0 <= i_req;
      end else if (state == BUF_ONE) begin
         if (push) ent1 <= i_req;
      end else if (pop) begin
         ent0 <= ent1;  // Shift up
      end
   end

   assign o_out.valid = (state != BUF_EMPTY);
   assign o_out.op    = ent0.op;
   assign o_out.pc    = ent0.pc;
   assign o_out.opa   = ent0.opa;
   assign o_out.opb   = ent0.opb;
   assign o_out.rop2  = ent0.rop2;
   assign o_out.epoch = ent0.epoch;

endmodule

//--- hw/exu_retire.sv
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_retire (
   input  logic               i_clk,
   input  logic               i_rst_n,
   exu_req_if.dst             i_in,
   input  exu_pkg::exu_res_t  i_alu_res,
   output logic               o_res_valid,
   input  logic               i_res_ready,
   output exu_pkg::exu_res_t  o_res,
   output logic               o_epoch
);

   logic take;
   logic stale;
   logic load;

   /////////////////////////////////////////
   // Accept and squash
   /////////////////////////////////////////

   // Free when empty or draining this cycle
   assign i_in.ready = ~o_res_valid | i_res_ready;

   assign take  = i_in.valid & i_in.ready;
   assign stale = (i_in.epoch != o_epoch);  // Wrong path fetch
   assign load  = take & ~stale;

   /////////////////////////////////////////
   // Result register and epoch
   /////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_res_valid <= 1'b0;
         o_epoch     <= 1'b0;
      end else begin
         if (load) begin
            o_res_valid <= 1'b1;
         end else if (i_res_ready) begin
            o_res_valid <= 1'b0;
         end

         // Flip at the edge the flushing result lands
         if (load && i_alu_res.flush) begin
            o_epoch <= ~o_epoch;
         end
      end
   end

   // Payload held while stalled
   always_ff @(posedge i_clk) begin
      if (load) begin
         o_res <= i_alu_res;
      end
   end

endmodule

//--- hw/exu_top.sv
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_top (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   // Request port
   input  logic                  i_req_valid,
   output logic                  o_req_ready,
   input  alu_pkg::alu_op_e      i_req_op,
   input  logic [`EXU_XLEN-1:0]  i_req_pc,
   input  logic [`EXU_XLEN-1:0]  i_req_opa,
   input  logic [`EXU_XLEN-1:0]  i_req_opb,
   input  logic [`EXU_XLEN-1:0]  i_req_rop2,
   input  logic                  i_req_epoch,
   // Result port
   output logic                  o_res_valid,
   input  logic                  i_res_ready,
   output logic [`EXU_XLEN-1:0]  o_res_data,
   output logic                  o_res_flush,
   output logic [`EXU_TGTW-1:0]  o_res_pc_tgt,
   output logic                  o_epoch
);
   import exu_pkg::*;

   exu_req_t req;
   exu_res_t alu_res;
   exu_res_t res;

   exu_req_if req_if ();

   assign req = '{op: i_req_op, pc: i_req_pc, opa: i_req_opa, opb: i_req_opb,
                  rop2: i_req_rop2, epoch: i_req_epoch};

   exu_issue_buf u_issue_buf (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_req_valid (i_req_valid),
      .o_req_ready (o_req_ready),
      .i_req       (req),
      .o_out       (req_if.src)
   );

   // Evaluates whatever the buffer head shows
   alu u_alu (
      .i_op   (req_if.op),
      .i_pc   (req_if.pc),
      .i_opa  (req_if.opa),
      .i_opb  (req_if.opb),
      .i_rop2 (req_if.rop2),
      .o_res  (alu_res)
   );

   exu_retire u_retire (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_in        (req_if.dst),
      .i_alu_res   (alu_res),
      .o_res_valid (o_res_valid),
      .i_res_ready (i_res_ready),
      .o_res       (res),
      .o_epoch     (o_epoch)
   );

   assign o_res_data   = res.data;
   assign o_res_flush  = res.flush;
   assign o_res_pc_tgt = res.pc_tgt;

endmodule

//--- tb/exu_tb_model.svh
`ifndef EXU_TB_MODEL_SVH
`define EXU_TB_MODEL_SVH

////////////////////////////////////////
// Stimulus source
////////////////////////////////////////

logic [15:0] lfsr_state = 16'd44252;

// x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
   logic [63:0] v;
   logic        fb;
   v = '0;
   for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[62:0], fb};
   end
   return v;
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////

exu_res_t exp_q [$];          // Results still owed, oldest first
logic     model_epoch = 1'b0;

function automatic logic branch_taken(input alu_op_e op, input logic [`EXU_XLEN-1:0] a,
                                      input logic [`EXU_XLEN-1:0] b);
   case (op)
      ALU_BEQ:  return a == b;
      ALU_BNE:  return a != b;
      ALU_BLT:  return $signed(a) < $signed(b);
      ALU_BGE:  return !($signed(a) < $signed(b));
      ALU_BLTU: return a < b;
      ALU_BGEU: return !(a < b);
      default:  return 1'b0;
   endcase
endfunction

function automatic exu_res_t model_result(input exu_req_t r);
   exu_res_t              res;
   logic                  taken;
   logic [`EXU_SHAMTW-1:0] shamt;
   shamt = r.opb[`EXU_SHAMTW-1:0];
   taken = alu_is_branch(r.op) && branch_taken(r.op, r.opa, r.rop2);
   res.flush = alu_is_jump(r.op) || taken;
   case (r.op)
      ALU_LUI:           res.data = r.opb;
      ALU_AUIPC:         res.data = r.pc + r.opb;
      ALU_JAL, ALU_JALR: res.data = (r.pc & ~64'd3) + 64'd4;
      ALU_ADD:           res.data = r.opa + r.opb;
      ALU_SUB:           res.data = r.opa - r.opb;
      ALU_AND:           res.data = r.opa & r.opb;
      ALU_OR:            res.data = r.opa | r.opb;
      ALU_XOR:           res.data = r.opa ^ r.opb;
      ALU_SLL:           res.data = (shamt >= `EXU_XLEN) ? '0 : r.opa << shamt;
      ALU_SRL:           res.data = (shamt >= `EXU_XLEN) ? '0 : r.opa >> shamt;
      ALU_SLT:           res.data = {63'd0, $signed(r.opa) < $signed(r.opb)};
      ALU_SLTU:          res.data = {63'd0, r.opa < r.opb};
      default:           res.data = '0;
   endcase
   if ((r.op == ALU_JAL) || taken) begin
      res.pc_tgt = r.pc[`EXU_XLEN-1:2] + r.opb[`EXU_XLEN-1:2];
   end else if (r.op == ALU_JALR) begin
      res.pc_tgt = r.opa[`EXU_XLEN-1:2] + r.opb[`EXU_XLEN-1:2];
   end else begin
      res.pc_tgt = '0;
   end
   return res;
endfunction

// Called in request order, a stale tag never retires
function automatic void expect_request(input exu_req_t r);
   exu_res_t res;
   if (r.epoch != model_epoch) return;
   res = model_result(r);
   exp_q.push_back(res);
   if (res.flush) model_epoch = !model_epoch;
endfunction

`endif

//--- tb/exu_tb.sv
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_tb;
   import alu_pkg::*;
   import exu_pkg::*;

   localparam int N_RANDOM        = 300;
   localparam int N_DIRECTED      = 43;
   localparam int WATCHDOG_CYCLES = (N_RANDOM + N_DIRECTED) * 40 + 200;
   localparam int DRAIN_CYCLES    = 40;  // Three in flight empty out well within this

   logic                 clk;
   logic                 rst_n;
   logic                 req_valid;
   logic                 req_ready;
   alu_op_e              req_op;
   logic [`EXU_XLEN-1:0] req_pc;
   logic [`EXU_XLEN-1:0] req_opa;
   logic [`EXU_XLEN-1:0] req_opb;
   logic [`EXU_XLEN-1:0] req_rop2;
   logic                 req_epoch;
   logic                 res_valid;
   logic                 res_ready;
   logic [`EXU_XLEN-1:0] res_data;
   logic                 res_flush;
   logic [`EXU_TGTW-1:0] res_pc_tgt;
   logic                 epoch;

   string test_name = "reset";
   int    errors    = 0;
   int    checks    = 0;
   int    res_count = 0;
   int    tests     = 0;
   int    err_start;
   int    chk_start;
   int    res_start;
   logic  throttle  = 1'b0;  // Random result back-pressure

   `include "exu_tb_model.svh"

   exu_top dut_i (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .i_req_valid  (req_valid),
      .o_req_ready  (req_ready),
      .i_req_op     (req_op),
      .i_req_pc     (req_pc),
      .i_req_opa    (req_opa),
      .i_req_opb    (req_opb),
      .i_req_rop2   (req_rop2),
      .i_req_epoch  (req_epoch),
      .o_res_valid  (res_valid),
      .i_res_ready  (res_ready),
      .o_res_data   (res_data),
      .o_res_flush  (res_flush),
      .o_res_pc_tgt (res_pc_tgt),
      .o_epoch      (epoch)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic check_value(input string what, input logic [`EXU_XLEN-1:0] exp,
                              input logic [`EXU_XLEN-1:0] act);
      checks++;
      assert (exp === act) else begin
         errors++;
         $display("Error %s: %s expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   always @(posedge clk) begin : monitor
      exu_req_t r;
      exu_res_t exp;
      if (rst_n) begin
         if (req_valid && req_ready) begin
            r.op    = req_op;
            r.pc    = req_pc;
            r.opa   = req_opa;
            r.opb   = req_opb;
            r.rop2  = req_rop2;
            r.epoch = req_epoch;
            expect_request(r);
         end
         if (res_valid && res_ready) begin
            res_count++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("Error %s: a result came out with none outstanding", test_name);
            end else begin
               exp = exp_q.pop_front();
               check_value("data", exp.data, res_data);
               check_value("flush", exp.flush, res_flush);
               check_value("pc_tgt", exp.pc_tgt, res_pc_tgt);
            end
         end
      end
   end

   assert property (@(posedge clk) $rose(rst_n) |-> (!res_valid && req_ready && !epoch))
      else begin
         errors++;
         $display("Error %s: outputs not at their idle values after reset", test_name);
      end

   // Held result must not move
   assert property (@(posedge clk) disable iff (!rst_n)
      (res_valid && !res_ready) |=> (res_valid && $stable(res_data) && $stable(res_flush)
                                     && $stable(res_pc_tgt)))
      else begin
         errors++;
         $display("Error %s: result changed while it was stalled", test_name);
      end

   assert property (@(posedge clk) disable iff (!rst_n)
      $fell(req_ready) |-> $past(res_valid && !res_ready))
      else begin
         errors++;
         $display("Error %s: request ready fell with no result held back", test_name);
      end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   task automatic start_test(input string name);
      test_name = name;
      tests++;
      err_start = errors;
      chk_start = checks;
      res_start = res_count;
   endtask

   task automatic end_test();
      $display("%-8s %0d compares, %0d results, %0d errors", test_name, checks - chk_start,
               res_count - res_start, errors - err_start);
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      if (throttle) res_ready <= (rand_bits(2) != 2'b00);
   endtask

   // Returns just after the edge that took the request
   task automatic send_req(input alu_op_e op, input logic [`EXU_XLEN-1:0] pc,
                           input logic [`EXU_XLEN-1:0] a, input logic [`EXU_XLEN-1:0] b,
                           input logic [`EXU_XLEN-1:0] c, input logic ep);
      req_valid <= 1'b1;
      req_op    <= op;
      req_pc    <= pc;
      req_opa   <= a;
      req_opb   <= b;
      req_rop2  <= c;
      req_epoch <= ep;
      do begin
         idle_cycle();
      end while (!req_ready);
      req_valid <= 1'b0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      res_ready <= 1'b1;
      @(posedge clk);
      while ((exp_q.size() != 0) && (waited < DRAIN_CYCLES)) begin
         @(posedge clk);
         waited++;
      end
      repeat (3) @(posedge clk);  // Dropped requests leave no trace
   endtask

   task automatic send_one(input alu_op_e op, input logic [`EXU_XLEN-1:0] pc,
                           input logic [`EXU_XLEN-1:0] a, input logic [`EXU_XLEN-1:0] b,
                           input logic [`EXU_XLEN-1:0] c);
      send_req(op, pc, a, b, c, epoch);
      drain();
   endtask

   // Equal, less, and negative against positive
   task automatic branch_trio(input alu_op_e op);
      send_one(op, 64'h4000_0010, 64'd5, 64'h80, 64'd5);
      send_one(op, 64'h4000_0010, 64'd5, 64'h80, 64'd9);
      send_one(op, 64'h4000_0012, -64'sd3, -64'sd16, 64'd4);
   endtask

   initial begin
      logic [`EXU_XLEN-1:0] a;
      logic [`EXU_XLEN-1:0] b;
      logic [`EXU_XLEN-1:0] c;
      logic [`EXU_XLEN-1:0] p;
      logic                 ep;
      int                   op_idx;
      rst_n     <= 1'b0;
      req_valid <= 1'b0;
      req_op    <= ALU_ADD;
      req_pc    <= '0;
      req_opa   <= '0;
      req_opb   <= '0;
      req_rop2  <= '0;
      req_epoch <= 1'b0;
      res_ready <= 1'b1;

      start_test("reset");
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_value("o_res_valid", 0, res_valid);
      check_value("o_req_ready", 1, req_ready);
      check_value("o_epoch", 0, epoch);
      end_test();

      start_test("alu");
      ep = epoch;
      send_req(ALU_ADD, 64'h100, 64'h7fff_ffff_ffff_ffff, 64'd1, '0, ep);
      @(posedge clk);
      check_value("o_res_valid at edge N+1", 0, res_valid);
      @(posedge clk);
      check_value("o_res_valid at edge N+2", 1, res_valid);
      send_req(ALU_SUB, '0, 64'd3, 64'd10, '0, ep);
      send_req(ALU_AND, '0, 64'hf0f0_1234_5678_ffff, 64'h0ff0_ffff_0000_1234, '0, ep);
      send_req(ALU_OR, '0, 64'hf0f0_1234_5678_ffff, 64'h0ff0_ffff_0000_1234, '0, ep);
      send_req(ALU_XOR, '0, 64'hf0f0_1234_5678_ffff, 64'h0ff0_ffff_0000_1234, '0, ep);
      send_req(ALU_SLL, '0, 64'h8000_0000_0000_0001, 64'd5, '0, ep);
      send_req(ALU_SLL, '0, 64'h8000_0000_0000_0001, 64'd63, '0, ep);
      send_req(ALU_SLL, '0, 64'hdead_beef, 64'd64, '0, ep);
      send_req(ALU_SLL, '0, 64'hdead_beef, 64'd100, '0, ep);
      send_req(ALU_SLL, '0, 64'hdead_beef, 64'd131, '0, ep);  // Only low 7 bits count
      send_req(ALU_SRL, '0, 64'h8000_0000_0000_0001, 64'd5, '0, ep);
      send_req(ALU_SRL, '0, 64'h8000_0000_0000_0001, 64'd63, '0, ep);
      send_req(ALU_SRL, '0, 64'hdead_beef, 64'd64, '0, ep);
      send_req(ALU_SRL, '0, 64'hdead_beef, 64'd127, '0, ep);
      send_req(ALU_SLT, '0, -64'sd5, 64'd3, '0, ep);
      send_req(ALU_SLTU, '0, -64'sd5, 64'd3, '0, ep);
      send_req(ALU_LUI, 64'h1234, 64'd9, 64'hffff_ffff_8765_4000, '0, ep);
      send_req(ALU_AUIPC, 64'h8000_1000, 64'd9, 64'h0000_0000_0012_3000, '0, ep);
      drain();
      end_test();

      start_test("branch");
      for (int k = 0; k < 6; k++) begin
         branch_trio(alu_op_e'(ALU_BEQ + k));
      end
      send_one(ALU_JAL, 64'h1000_0006, 64'd0, 64'h20, 64'd0);
      send_one(ALU_JALR, 64'h1000_0000, 64'h2000_0003, 64'h14, 64'd0);
      end_test();

      start_test("epoch");
      ep = epoch;
      send_req(ALU_JAL, 64'h2000, '0, 64'h40, '0, ep);
      send_req(ALU_ADD, '0, 64'd1, 64'd2, '0, ep);  // Wrong path from here
      send_req(ALU_SUB, '0, 64'd1, 64'd2, '0, ep);
      send_req(ALU_OR, '0, 64'd1, 64'd2, '0, ep);
      drain();
      check_value("o_epoch", !ep, epoch);
      send_req(ALU_ADD, '0, 64'd7, 64'd8, '0, epoch);
      drain();
      check_value("result count", 2, res_count - res_start);
      end_test();

      start_test("random");
      throttle = 1'b1;
      for (int n = 0; n < N_RANDOM; n++) begin
         op_idx = rand_bits(5) % 19;
         p = rand_bits(64);
         a = rand_bits(64);
         b = rand_bits(64);
         if (rand_bits(1)) b = rand_bits(7);
         c = rand_bits(64);
         if (rand_bits(2) == 0) c = a;
         ep = epoch;
         if (rand_bits(3) == 0) ep = !ep;
         send_req(alu_op_e'(5'(op_idx)), p, a, b, c, ep);
         if (rand_bits(2) == 0) idle_cycle();
      end
      throttle = 1'b0;
      drain();
      check_value("results still owed", 0, exp_q.size());
      end_test();

      $display("Summary: %0d tests, %0d compares, %0d results, %0d errors", tests, checks,
               res_count, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+hw
+incdir+tb
hw/alu_pkg.sv
hw/exu_pkg.sv
hw/exu_req_if.sv
hw/alu.sv
hw/exu_issue_buf.sv
hw/exu_retire.sv
hw/exu_top.sv
tb/exu_tb.sv
